/* tb.f */
+incdir+source
source/fetch_pkg.sv
source/imem.sv
source/predecode.sv
source/bimodal_predictor.sv
source/next_pc_ctrl.sv
source/fetch_top.sv
verification/fetch_props.sv
verification/fetch_tb.sv

/* verification/fetch_tb.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_tb import fetch_pkg::*; ();

    // one table row, one clock cycle
    typedef struct packed {
        int                      test;
        logic                    stall;
        logic                    misp;
        pc_t                     rec_pc;
        logic                    ld;
        pc_t                     ld_pc;
        logic                    upd;
        pc_t                     upd_pc;
        logic                    upd_tk;
        pc_t                     exp_pc;
        logic [`FETCH_WIDTH-1:0] exp_valid;
        logic [`FETCH_WIDTH-1:0] exp_pred;
    } row_t;

    logic                                clk;
    logic                                rst_n;
    logic                                imem_we;
    pc_t                                 imem_addr;
    inst_t                               imem_wdata;
    logic                                stall_fetch;
    logic                                has_mispredict;
    pc_t                                 pc_recovery;
    logic                                exter_pc_en;
    pc_t                                 exter_pc;
    logic                                update_en;
    pc_t                                 update_pc;
    logic                                update_taken;
    logic [`FETCH_WIDTH*`PC_WIDTH-1:0]   pc_to_dec;
    logic [`FETCH_WIDTH*`PC_WIDTH-1:0]   inst_to_dec;
    logic [`FETCH_WIDTH-1:0]             pred_to_dec;
    logic [`FETCH_WIDTH-1:0]             slot_valid_to_dec;

    inst_t  prog [`IMEM_DEPTH];
    row_t   rows [$];
    integer seed;
    int     errors;
    int     checks;
    int     cycles;
    int     limit;

    fetch_top u_dut (
        .clk               (clk),
        .rst_n             (rst_n),
        .imem_we           (imem_we),
        .imem_addr         (imem_addr),
        .imem_wdata        (imem_wdata),
        .stall_fetch       (stall_fetch),
        .has_mispredict    (has_mispredict),
        .pc_recovery       (pc_recovery),
        .exter_pc_en       (exter_pc_en),
        .exter_pc          (exter_pc),
        .update_en         (update_en),
        .update_pc         (update_pc),
        .update_taken      (update_taken),
        .pc_to_dec         (pc_to_dec),
        .inst_to_dec       (inst_to_dec),
        .pred_to_dec       (pred_to_dec),
        .slot_valid_to_dec (slot_valid_to_dec)
    );

    //////////////////////////////
    // clock and watchdog
    //////////////////////////////

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // limit is set by the main process at time 0
    initial begin
        cycles = 0;
        @(posedge clk);
        while (cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run still going after %0d clock cycles", cycles);
        $display(">>> FAIL");
        $finish;
    end

    //////////////////////////////
    // program and table
    //////////////////////////////

    // random filler, control opcodes C and D folded away
    task automatic build_program();
        inst_t w;
        for (int a = 0; a < `IMEM_DEPTH; a++) begin
            w = inst_t'($random(seed));
            if (w[15:13] == 3'b110) begin
                w[15] = 1'b0;
            end
            prog[a] = w;
        end
        // jump at 0x1a, 0x1b + 0x15 = 0x30
        prog['h1A] = {`OP_JUMP, 12'h015};
        // branch at 0x31, 0x32 + 0x0e = 0x40
        prog['h31] = {`OP_BRANCH, 4'h0, 8'h0E};
    endtask

    task automatic add_row(input int test, input int stall, input int misp, input pc_t rec_pc,
                           input int ld, input pc_t ld_pc, input int upd, input pc_t upd_pc,
                           input int upd_tk, input pc_t exp_pc,
                           input logic [`FETCH_WIDTH-1:0] exp_valid,
                           input logic [`FETCH_WIDTH-1:0] exp_pred);
        row_t rw;
        rw.test      = test;
        rw.stall     = (stall != 0);
        rw.misp      = (misp != 0);
        rw.rec_pc    = rec_pc;
        rw.ld        = (ld != 0);
        rw.ld_pc     = ld_pc;
        rw.upd       = (upd != 0);
        rw.upd_pc    = upd_pc;
        rw.upd_tk    = (upd_tk != 0);
        rw.exp_pc    = exp_pc;
        rw.exp_valid = exp_valid;
        rw.exp_pred  = exp_pred;
        rows.push_back(rw);
    endtask

    // test stall misp rec ld ld_pc upd upd_pc tk | exp pc, valid, pred
    task automatic build_table();
        // straight line from 0x10
        add_row(1, 0, 0, 16'h0000, 0, 16'h0000, 0, 16'h0000, 0, 16'h0010, 4'b1111, 4'b0000);
        add_row(1, 0, 0, 16'h0000, 0, 16'h0000, 0, 16'h0000, 0, 16'h0014, 4'b1111, 4'b0000);
        // jump in slot 2 cuts slot 3
        add_row(2, 0, 0, 16'h0000, 0, 16'h0000, 0, 16'h0000, 0, 16'h0018, 4'b0111, 4'b0000);
        // untouched counter falls through
        add_row(3, 0, 0, 16'h0000, 0, 16'h0000, 0, 16'h0000, 0, 16'h0030, 4'b1111, 4'b0000);
        // two taken updates, then reload 0x30
        add_row(4, 0, 0, 16'h0000, 0, 16'h0000, 1, 16'h0031, 1, 16'h0034, 4'b1111, 4'b0000);
        add_row(4, 0, 0, 16'h0000, 0, 16'h0000, 1, 16'h0031, 1, 16'h0038, 4'b1111, 4'b0000);
        add_row(4, 0, 0, 16'h0000, 1, 16'h0030, 0, 16'h0000, 0, 16'h003C, 4'b0000, 4'b0000);
        add_row(4, 0, 0, 16'h0000, 0, 16'h0000, 0, 16'h0000, 0, 16'h0030, 4'b0011, 4'b0010);
        // back down to weak not-taken
        add_row(4, 0, 0, 16'h0000, 0, 16'h0000, 1, 16'h0031, 0, 16'h0040, 4'b1111, 4'b0000);
        add_row(4, 0, 0, 16'h0000, 0, 16'h0000, 1, 16'h0031, 0, 16'h0044, 4'b1111, 4'b0000);
        add_row(4, 0, 0, 16'h0000, 1, 16'h0030, 0, 16'h0000, 0, 16'h0048, 4'b0000, 4'b0000);
        add_row(4, 0, 0, 16'h0000, 0, 16'h0000, 0, 16'h0000, 0, 16'h0030, 4'b1111, 4'b0000);
        // stall holds 0x34 for two cycles
        add_row(5, 1, 0, 16'h0000, 0, 16'h0000, 0, 16'h0000, 0, 16'h0034, 4'b0000, 4'b0000);
        add_row(5, 1, 0, 16'h0000, 0, 16'h0000, 0, 16'h0000, 0, 16'h0034, 4'b0000, 4'b0000);
        add_row(5, 0, 0, 16'h0000, 0, 16'h0000, 0, 16'h0000, 0, 16'h0034, 4'b1111, 4'b0000);
        // recovery to 0x10
        add_row(5, 0, 1, 16'h0010, 0, 16'h0000, 0, 16'h0000, 0, 16'h0038, 4'b0000, 4'b0000);
        add_row(5, 0, 0, 16'h0000, 0, 16'h0000, 0, 16'h0000, 0, 16'h0010, 4'b1111, 4'b0000);
        // load beats mispredict
        add_row(5, 0, 1, 16'h0030, 1, 16'h0018, 0, 16'h0000, 0, 16'h0014, 4'b0000, 4'b0000);
        add_row(5, 0, 0, 16'h0000, 0, 16'h0000, 0, 16'h0000, 0, 16'h0018, 4'b0111, 4'b0000);
        // mispredict beats stall
        add_row(5, 1, 1, 16'h0014, 0, 16'h0000, 0, 16'h0000, 0, 16'h0030, 4'b0000, 4'b0000);
        add_row(5, 0, 0, 16'h0000, 0, 16'h0000, 0, 16'h0000, 0, 16'h0014, 4'b1111, 4'b0000);
    endtask

    function automatic string test_name(input int test);
        case (test)
            1:       return "sequential";
            2:       return "jump";
            3:       return "untrained branch";
            4:       return "trained branch";
            default: return "stall/mispredict/load";
        endcase
    endfunction

    //////////////////////////////
    // drive and check
    //////////////////////////////

    task automatic apply_row(input row_t rw);
        stall_fetch    <= rw.stall;
        has_mispredict <= rw.misp;
        pc_recovery    <= rw.rec_pc;
        exter_pc_en    <= rw.ld;
        exter_pc       <= rw.ld_pc;
        update_en      <= rw.upd;
        update_pc      <= rw.upd_pc;
        update_taken   <= rw.upd_tk;
    endtask

    task automatic check_row(input int r);
        row_t  rw;
        int    bad;
        pc_t   exp_slot_pc;
        pc_t   got_pc;
        inst_t got_inst;
        inst_t exp_inst;
        rw  = rows[r];
        bad = 0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            exp_slot_pc = rw.exp_pc + pc_t'(i);
            exp_inst    = prog[exp_slot_pc % `IMEM_DEPTH];
            got_pc      = pc_to_dec[i*`PC_WIDTH +: `PC_WIDTH];
            got_inst    = inst_to_dec[i*`PC_WIDTH +: `PC_WIDTH];
            checks += 2;
            assert (got_pc == exp_slot_pc) else begin
                $display("FAIL %0t: row %0d slot %0d pc %h, expected %h",
                         $time, r, i, got_pc, exp_slot_pc);
                bad++;
            end
            assert (got_inst == exp_inst) else begin
                $display("FAIL %0t: row %0d slot %0d inst %h, expected %h",
                         $time, r, i, got_inst, exp_inst);
                bad++;
            end
        end
        checks += 2;
        assert (slot_valid_to_dec == rw.exp_valid) else begin
            $display("FAIL %0t: row %0d valid %b, expected %b",
                     $time, r, slot_valid_to_dec, rw.exp_valid);
            bad++;
        end
        assert (pred_to_dec == rw.exp_pred) else begin
            $display("FAIL %0t: row %0d pred %b, expected %b",
                     $time, r, pred_to_dec, rw.exp_pred);
            bad++;
        end
        errors += bad;
        $display("row %0d %s: pc %h valid %b pred %b, %s", r, test_name(rw.test),
                 rw.exp_pc, rw.exp_valid, rw.exp_pred, (bad == 0) ? "ok" : "mismatch");
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        rst_n          = 1'b0;
        imem_we        = 1'b0;
        imem_addr      = '0;
        imem_wdata     = '0;
        stall_fetch    = 1'b0;
        has_mispredict = 1'b0;
        pc_recovery    = '0;
        exter_pc_en    = 1'b0;
        exter_pc       = '0;
        update_en      = 1'b0;
        update_pc      = '0;
        update_taken   = 1'b0;
        errors         = 0;
        checks         = 0;
        seed           = 32'hb45b;
        build_program();
        build_table();
        // reset, program writes, pc load, table, margin
        limit = 4 + `IMEM_DEPTH + 2 + rows.size() + 20;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;

        // program goes in through the imem write port
        for (int a = 0; a < `IMEM_DEPTH; a++) begin
            @(posedge clk);
            imem_we    <= 1'b1;
            imem_addr  <= pc_t'(a);
            imem_wdata <= prog[a];
        end
        @(posedge clk);
        imem_we     <= 1'b0;
        exter_pc_en <= 1'b1;
        exter_pc    <= 16'h0010;

        // outputs settle by the falling edge
        for (int r = 0; r < rows.size(); r++) begin
            @(posedge clk);
            apply_row(rows[r]);
            @(negedge clk);
            check_row(r);
        end
        @(posedge clk);
        apply_row('0);

        $display("rows %0d, checks %0d, errors %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* verification/fetch_props.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_props import fetch_pkg::*; (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    stall_fetch,
    input logic                    has_mispredict,
    input pc_t                     pc_recovery,
    input logic                    exter_pc_en,
    input pc_t                     pc,
    input logic [`FETCH_WIDTH-1:0] slot_valid
);

    // mask plus one clears a prefix of ones
    logic [`FETCH_WIDTH-1:0] valid_inc;

    assign valid_inc = slot_valid + 1'b1;

    //////////////////////////////
    // valid mask
    //////////////////////////////

    a_valid_prefix: assert property (@(posedge clk) disable iff (!rst_n)
        (slot_valid & valid_inc) == '0)
        else $error("slot_valid %b is not a prefix of ones", slot_valid);

    a_drop_group: assert property (@(posedge clk) disable iff (!rst_n)
        (stall_fetch || has_mispredict || exter_pc_en) |-> slot_valid == '0)
        else $error("slot_valid %b while group is dropped", slot_valid);

    //////////////////////////////
    // pc holds and redirects
    //////////////////////////////

    // only when nothing above stall in priority
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (stall_fetch && !has_mispredict && !exter_pc_en) |=> pc == $past(pc))
        else $error("pc moved during stall");

    a_recovery: assert property (@(posedge clk) disable iff (!rst_n)
        (has_mispredict && !exter_pc_en) |=> pc == $past(pc_recovery))
        else $error("pc did not take pc_recovery after mispredict");

endmodule

bind next_pc_ctrl fetch_props u_props (
    .clk            (clk),
    .rst_n          (rst_n),
    .stall_fetch    (stall_fetch),
    .has_mispredict (has_mispredict),
    .pc_recovery    (pc_recovery),
    .exter_pc_en    (exter_pc_en),
    .pc             (pc),
    .slot_valid     (slot_valid)
);

/* source/fetch_top.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_top import fetch_pkg::*; (
    input  logic                                clk,
    input  logic                                rst_n,
    // imem test write port
    input  logic                                imem_we,
    input  pc_t                                 imem_addr,
    input  inst_t                               imem_wdata,
    // pipeline control
    input  logic                                stall_fetch,
    input  logic                                has_mispredict,
    input  pc_t                                 pc_recovery,
    input  logic                                exter_pc_en,
    input  pc_t                                 exter_pc,
    // predictor training
    input  logic                                update_en,
    input  pc_t                                 update_pc,
    input  logic                                update_taken,
    // decode buses, slot 0 in low bits
    output logic [`FETCH_WIDTH*`PC_WIDTH-1:0]   pc_to_dec,
    output logic [`FETCH_WIDTH*`PC_WIDTH-1:0]   inst_to_dec,
    output logic [`FETCH_WIDTH-1:0]             pred_to_dec,
    output logic [`FETCH_WIDTH-1:0]             slot_valid_to_dec
);

    pc_t                     pc;
    inst_t                   inst   [`FETCH_WIDTH];
    slot_kind_t              kind   [`FETCH_WIDTH];
    pc_t                     target [`FETCH_WIDTH];
    logic [`FETCH_WIDTH-1:0] pred_taken;

    //////////////////////////////
    // fetch blocks
    //////////////////////////////

    imem u_imem (
        .clk     (clk),
        .we      (imem_we),
        .waddr   (imem_addr),
        .wdata   (imem_wdata),
        .pc      (pc),
        .rd_inst (inst)
    );

    predecode u_predecode (
        .pc     (pc),
        .inst   (inst),
        .kind   (kind),
        .target (target)
    );

    bimodal_predictor u_bpred (
        .clk          (clk),
        .rst_n        (rst_n),
        .pc           (pc),
        .update_en    (update_en),
        .update_pc    (update_pc),
        .update_taken (update_taken),
        .pred_taken   (pred_taken)
    );

    next_pc_ctrl u_npc (
        .clk            (clk),
        .rst_n          (rst_n),
        .stall_fetch    (stall_fetch),
        .has_mispredict (has_mispredict),
        .pc_recovery    (pc_recovery),
        .exter_pc_en    (exter_pc_en),
        .exter_pc       (exter_pc),
        .kind           (kind),
        .target         (target),
        .pred_taken     (pred_taken),
        .pc             (pc),
        .slot_valid     (slot_valid_to_dec)
    );

    //////////////////////////////
    // decode packing
    //////////////////////////////

    genvar i;
    generate
        for (i = 0; i < `FETCH_WIDTH; i++) begin : g_pack
            // slot i sits at pc + i
            assign pc_to_dec[i*`PC_WIDTH +: `PC_WIDTH]   = pc + `PC_WIDTH'(i);
            assign inst_to_dec[i*`PC_WIDTH +: `PC_WIDTH] = inst[i];
        end
    endgenerate

    assign pred_to_dec = pred_taken;

endmodule

/* source/next_pc_ctrl.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module next_pc_ctrl import fetch_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    // hold request from decode
    input  logic                    stall_fetch,
    // recovery from commit
    input  logic                    has_mispredict,
    input  pc_t                     pc_recovery,
    // test pc load
    input  logic                    exter_pc_en,
    input  pc_t                     exter_pc,
    // per-slot predecode and prediction
    input  slot_kind_t              kind       [`FETCH_WIDTH],
    input  pc_t                     target     [`FETCH_WIDTH],
    input  logic [`FETCH_WIDTH-1:0] pred_taken,
    output pc_t                     pc,
    output logic [`FETCH_WIDTH-1:0] slot_valid
);

    logic [`FETCH_WIDTH-1:0] redirect;
    logic [`FETCH_WIDTH-1:0] keep_mask;
    logic                    redirect_any;
    pc_t                     redirect_pc;
    pc_t                     pc_nxt;
    logic                    group_drop;

    //////////////////////////////
    // first redirecting slot
    //////////////////////////////

    // jumps always redirect and branches only when predicted taken
    always_comb begin
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            redirect[i] = (kind[i] == KIND_JUMP) ||
                          ((kind[i] == KIND_BRANCH) && pred_taken[i]);
        end
    end

    // scan from the oldest slot and keep up to the first redirect
    always_comb begin
        redirect_any = 1'b0;
        redirect_pc  = '0;
        keep_mask    = '0;
        for (int i = 0; i < `FETCH_WIDTH; i++) begin
            if (!redirect_any) begin
                keep_mask[i] = 1'b1;
                if (redirect[i]) begin
                    redirect_any = 1'b1;
                    redirect_pc  = target[i];
                end
            end
        end
    end

    //////////////////////////////
    // next pc priority
    //////////////////////////////

    always_comb begin
        if (exter_pc_en) begin
            pc_nxt = exter_pc;
        end else if (has_mispredict) begin
            pc_nxt = pc_recovery;
        end else if (stall_fetch) begin
            // hold so the group is replayed
            pc_nxt = pc;
        end else if (redirect_any) begin
            pc_nxt = redirect_pc;
        end else begin
            pc_nxt = pc + `PC_WIDTH'(`FETCH_WIDTH);
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else begin
            pc <= pc_nxt;
        end
    end

    //////////////////////////////
    // valid mask to decode
    //////////////////////////////

    // group is thrown away in reset or on any of these
    assign group_drop = stall_fetch || has_mispredict || exter_pc_en || !rst_n;
    assign slot_valid = group_drop ? '0 : keep_mask;

endmodule

/* source/bimodal_predictor.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module bimodal_predictor import fetch_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    // group base address
    input  pc_t                     pc,
    // commit-side training
    input  logic                    update_en,
    input  pc_t                     update_pc,
    input  logic                    update_taken,
    // one bit per slot, slot 0 in bit 0
    output logic [`FETCH_WIDTH-1:0] pred_taken
);

    // table index width
    localparam int IW = $clog2(`BHT_ENTRIES);

    ctr_t          bht [`BHT_ENTRIES];
    logic [IW-1:0] upd_idx;

    //////////////////////////////
    // saturating step
    //////////////////////////////

    function automatic ctr_t ctr_step(input ctr_t cur, input logic up);
        ctr_t res;
        res = cur;
        if (up) begin
            // stop at strong taken
            if (cur != CTR_ST) begin
                res = ctr_t'(cur + 2'd1);
            end
        end else begin
            // stop at strong not-taken
            if (cur != CTR_SNT) begin
                res = ctr_t'(cur - 2'd1);
            end
        end
        return res;
    endfunction

    //////////////////////////////
    // training
    //////////////////////////////

    assign upd_idx = update_pc[IW-1:0];

    // one update per cycle, lookups see it next cycle
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int e = 0; e < `BHT_ENTRIES; e++) begin
                bht[e] <= CTR_RESET;
            end
        end else if (update_en) begin
            bht[upd_idx] <= ctr_step(bht[upd_idx], update_taken);
        end
    end

    //////////////////////////////
    // four lookups
    //////////////////////////////

    genvar i;
    generate
        for (i = 0; i < `FETCH_WIDTH; i++) begin : g_look
            logic [IW-1:0] idx;
            // low bits of pc + i
            assign idx           = pc[IW-1:0] + IW'(i);
            // taken when counter upper bit set
            assign pred_taken[i] = bht[idx][1];
        end
    endgenerate

endmodule

/* source/predecode.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module predecode import fetch_pkg::*; (
    // group base address
    input  pc_t        pc,
    input  inst_t      inst   [`FETCH_WIDTH],
    output slot_kind_t kind   [`FETCH_WIDTH],
    output pc_t        target [`FETCH_WIDTH]
);

    //////////////////////////////
    // per-slot decode
    //////////////////////////////

    genvar i;
    generate
        for (i = 0; i < `FETCH_WIDTH; i++) begin : g_slot
            pc_t        slot_pc;
            pc_t        fall_pc;
            pc_t        br_off;
            pc_t        jmp_off;
            logic [3:0] opcode;

            assign slot_pc = pc + `PC_WIDTH'(i);
            // targets are relative to the following word
            assign fall_pc = slot_pc + `PC_WIDTH'(1);
            assign opcode  = inst[i][15:12];

            // sign extend both offset fields
            assign br_off  = {{(`PC_WIDTH-8){inst[i][7]}}, inst[i][7:0]};
            assign jmp_off = {{(`PC_WIDTH-12){inst[i][11]}}, inst[i][11:0]};

            always_comb begin
                case (opcode)
                    `OP_BRANCH: begin
                        kind[i]   = KIND_BRANCH;
                        target[i] = fall_pc + br_off;
                    end
                    `OP_JUMP: begin
                        kind[i]   = KIND_JUMP;
                        target[i] = fall_pc + jmp_off;
                    end
                    default: begin
                        // not a control word
                        kind[i]   = KIND_OTHER;
                        target[i] = '0;
                    end
                endcase
            end
        end
    endgenerate

endmodule

/* source/imem.sv */
`timescale 1ns/1ps
`include "fetch_params.svh"

module imem import fetch_pkg::*; (
    input  logic  clk,
    // test write port
    input  logic  we,
    input  pc_t   waddr,
    input  inst_t wdata,
    // group base address
    input  pc_t   pc,
    output inst_t rd_inst [`FETCH_WIDTH]
);

    // word address bits actually decoded
    localparam int AW = $clog2(`IMEM_DEPTH);

    inst_t mem [`IMEM_DEPTH];

    //////////////////////////////
    // write side
    //////////////////////////////

    // visible to reads from the next cycle
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr[AW-1:0]] <= wdata;
        end
    end

    //////////////////////////////
    // four read ports
    //////////////////////////////

    genvar i;
    generate
        for (i = 0; i < `FETCH_WIDTH; i++) begin : g_rd
            logic [AW-1:0] raddr;
            // pc + i, wraps at the top of memory
            assign raddr      = pc[AW-1:0] + AW'(i);
            assign rd_inst[i] = mem[raddr];
        end
    endgenerate

endmodule

/* source/fetch_pkg.sv */
`include "fetch_params.svh"

package fetch_pkg;

    //////////////////////////////
    // basic words
    //////////////////////////////

    // word address
    typedef logic [`PC_WIDTH-1:0] pc_t;
    // one instruction word
    typedef logic [`PC_WIDTH-1:0] inst_t;

    //////////////////////////////
    // predictor state
    //////////////////////////////

    // upper bit set means predict taken
    typedef enum logic [1:0] {
        CTR_SNT = 2'b00,
        CTR_WNT = 2'b01,
        CTR_WT  = 2'b10,
        CTR_ST  = 2'b11
    } ctr_t;

    // counter value out of reset
    localparam ctr_t CTR_RESET = CTR_WNT;

    // predecode class of one slot
    typedef enum logic [1:0] {
        KIND_OTHER  = 2'b00,
        KIND_BRANCH = 2'b01,
        KIND_JUMP   = 2'b10
    } slot_kind_t;

endpackage

/* source/fetch_params.svh */
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

//////////////////////////////
// fetch geometry
//////////////////////////////

// slots per fetch group
`define FETCH_WIDTH 4
// pc and instruction width, word addressed
`define PC_WIDTH 16
// instruction words in imem
`define IMEM_DEPTH 256
// bimodal counters, indexed by low pc bits
`define BHT_ENTRIES 64

//////////////////////////////
// major opcodes, inst[15:12]
//////////////////////////////

// conditional branch, signed offset in inst[7:0]
`define OP_BRANCH 4'hC
// immediate jump, signed offset in inst[11:0]
`define OP_JUMP 4'hD

`endif
